//--- source/cache_pkg.sv
package cache_pkg;

    // ------------------------------
    // Address split
    // ------------------------------
    // Tag 31:12, index 11:6, offset 5:0
    localparam int unsigned addr_w   = 32;
    localparam int unsigned offset_w = 6;
    localparam int unsigned index_w  = 6;
    localparam int unsigned tag_w    = addr_w - index_w - offset_w;

    // ------------------------------
    // Geometry
    // ------------------------------
    localparam int unsigned num_sets = 1 << index_w;
    localparam int unsigned num_ways = 4;

    // Tree bits per set: root, pair 0/1, pair 2/3
    localparam int unsigned plru_w = num_ways - 1;

    // ------------------------------
    // One-hot way selects
    // ------------------------------
    localparam logic [num_ways-1:0] way0 = 4'b0001;
    localparam logic [num_ways-1:0] way1 = 4'b0010;
    localparam logic [num_ways-1:0] way2 = 4'b0100;
    localparam logic [num_ways-1:0] way3 = 4'b1000;

endpackage

//--- source/tagv_ram.sv
`timescale 1ns/1ps

module tagv_ram (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  logic [cache_pkg::index_w-1:0] wr_index,
    input  logic [cache_pkg::tag_w-1:0]   wr_tag,
    input  logic [cache_pkg::index_w-1:0] rd_index,
    output logic [cache_pkg::tag_w-1:0]   rd_tag,
    output logic                          rd_vld
);
    import cache_pkg::*;

    logic [tag_w-1:0]    tag_mem [num_sets];
    logic [num_sets-1:0] vld_q;

    // Tag storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
    end

    // Valid bits, cleared only by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else if (wr_en) begin
            vld_q[wr_index] <= 1'b1;
        end
    end

    // Registered read port, old data on a same-index write
    always_ff @(posedge clk) begin
        rd_tag <= tag_mem[rd_index];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= vld_q[rd_index];
        end
    end

endmodule

//--- source/tagv_memory.sv
`timescale 1ns/1ps

module tagv_memory (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cache_pkg::index_w-1:0]  rd_index,
    input  logic [cache_pkg::index_w-1:0]  wr_index,
    input  logic [cache_pkg::tag_w-1:0]    wr_tag,
    input  logic [cache_pkg::tag_w-1:0]    lookup_tag,
    input  logic [cache_pkg::num_ways-1:0] we,
    input  logic [cache_pkg::num_ways-1:0] way_sel,
    output logic [cache_pkg::num_ways-1:0] hit,
    output logic                           cache_hit,
    output logic [cache_pkg::tag_w-1:0]    replace_tag,
    output logic                           replace_vld
);
    import cache_pkg::*;

    logic [tag_w-1:0] way_tag [num_ways];
    logic             way_vld [num_ways];

    // ------------------------------
    // Way storage
    // ------------------------------
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        tagv_ram i_tagv_ram (
            .clk      (clk),
            .reset    (reset),
            .wr_en    (we[w]),
            .wr_index (wr_index),
            .wr_tag   (wr_tag),
            .rd_index (rd_index),
            .rd_tag   (way_tag[w]),
            .rd_vld   (way_vld[w])
        );

        assign hit[w] = way_vld[w] && (way_tag[w] == lookup_tag);
    end

    assign cache_hit = |hit;

    // ------------------------------
    // Replace mux
    // ------------------------------
    always_comb begin
        case (way_sel)
            way0: begin
                replace_tag = way_tag[0];
                replace_vld = way_vld[0];
            end
            way1: begin
                replace_tag = way_tag[1];
                replace_vld = way_vld[1];
            end
            way2: begin
                replace_tag = way_tag[2];
                replace_vld = way_vld[2];
            end
            way3: begin
                replace_tag = way_tag[3];
                replace_vld = way_vld[3];
            end
            default: begin
                replace_tag = '0;
                replace_vld = 1'b0;
            end
        endcase
    end

    // A tag is only ever filled into one way of a set
    a_hit_onehot0 : assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(hit)
    ) else $error("tagv_memory: more than one way hits");

endmodule

//--- source/plru_replacer.sv
`timescale 1ns/1ps

module plru_replacer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [cache_pkg::index_w-1:0]  sel_index,
    output logic [cache_pkg::num_ways-1:0] victim,
    input  logic                           acc_valid,
    input  logic [cache_pkg::index_w-1:0]  acc_index,
    input  logic [cache_pkg::num_ways-1:0] acc_way
);
    import cache_pkg::*;

    logic [plru_w-1:0] tree_q [num_sets];
    logic [plru_w-1:0] sel_tree;
    logic [plru_w-1:0] acc_tree;
    logic [plru_w-1:0] acc_next;

    // ------------------------------
    // Victim select
    // ------------------------------
    assign sel_tree = tree_q[sel_index];

    always_comb begin
        if (!sel_tree[0]) begin
            victim = sel_tree[1] ? way1 : way0;
        end else begin
            victim = sel_tree[2] ? way3 : way2;
        end
    end

    // ------------------------------
    // Update on access
    // ------------------------------
    assign acc_tree = tree_q[acc_index];

    // Point the tree away from the way just used
    always_comb begin
        acc_next = acc_tree;
        case (acc_way)
            way0: acc_next = {acc_tree[2], 1'b1, 1'b1};
            way1: acc_next = {acc_tree[2], 1'b0, 1'b1};
            way2: acc_next = {1'b1, acc_tree[1], 1'b0};
            way3: acc_next = {1'b0, acc_tree[1], 1'b0};
            default: acc_next = acc_tree;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                tree_q[s] <= '0;
            end
        end else if (acc_valid) begin
            tree_q[acc_index] <= acc_next;
        end
    end

    a_acc_onehot : assert property (
        @(posedge clk) disable iff (reset)
        acc_valid |-> $onehot(acc_way)
    ) else $error("plru_replacer: access way is not one-hot");

endmodule

//--- source/lookup_queue.sv
`timescale 1ns/1ps

module lookup_queue #(
    parameter int unsigned queue_depth = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  logic [cache_pkg::addr_w-1:0] req_addr,
    output logic                         q_valid,
    output logic [cache_pkg::addr_w-1:0] q_addr,
    input  logic                         q_pop,
    output logic                         credit_return
);
    import cache_pkg::*;

    localparam int unsigned ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int unsigned cnt_w = $clog2(queue_depth + 1);

    logic [addr_w-1:0] mem [queue_depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;

    assign q_valid = (count != '0);
    assign q_addr  = mem[rd_ptr];

    // Entry storage
    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req_addr;
        end
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit back per freed entry
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= q_pop;
        end
    end

    // Credit discipline of the requester keeps the queue from overflowing
    a_no_overflow : assert property (
        @(posedge clk) disable iff (reset)
        req_valid |-> (count != cnt_w'(queue_depth))
    ) else $error("lookup_queue: push into full queue");

    a_no_underflow : assert property (
        @(posedge clk) disable iff (reset)
        q_pop |-> (count != '0)
    ) else $error("lookup_queue: pop from empty queue");

endmodule

//--- source/lookup_ctrl.sv
`timescale 1ns/1ps

module lookup_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    // Queue side
    input  logic                           q_valid,
    input  logic [cache_pkg::addr_w-1:0]   q_addr,
    output logic                           q_pop,
    // Memory side
    output logic [cache_pkg::index_w-1:0]  rd_index,
    output logic [cache_pkg::index_w-1:0]  wr_index,
    output logic [cache_pkg::tag_w-1:0]    wr_tag,
    output logic [cache_pkg::tag_w-1:0]    lookup_tag,
    output logic [cache_pkg::num_ways-1:0] we,
    input  logic [cache_pkg::num_ways-1:0] hit,
    input  logic                           cache_hit,
    input  logic [cache_pkg::tag_w-1:0]    replace_tag,
    input  logic                           replace_vld,
    // Replacer side
    output logic [cache_pkg::index_w-1:0]  sel_index,
    input  logic [cache_pkg::num_ways-1:0] victim,
    output logic                           acc_valid,
    output logic [cache_pkg::index_w-1:0]  acc_index,
    output logic [cache_pkg::num_ways-1:0] acc_way,
    // Response
    output logic                           resp_valid,
    output logic                           resp_hit,
    output logic [cache_pkg::num_ways-1:0] resp_way,
    output logic [cache_pkg::tag_w-1:0]    resp_evict_tag,
    output logic                           resp_evict_valid
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_compare
    } state_t;

    state_t            state;
    logic [addr_w-1:0] addr_q;
    logic [tag_w-1:0]  cur_tag;
    logic [index_w-1:0] cur_index;
    logic              in_compare;

    assign cur_tag    = addr_q[addr_w-1 -: tag_w];
    assign cur_index  = addr_q[offset_w +: index_w];
    assign in_compare = (state == st_compare);

    assign q_pop = (state == st_idle) && q_valid;

    // ------------------------------
    // Sequencer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    state <= q_valid ? st_read : st_idle;
                st_read:    state <= st_compare;
                st_compare: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            addr_q <= q_addr;
        end
    end

    // Tag read and fill share the latched address
    assign rd_index   = cur_index;
    assign lookup_tag = cur_tag;
    assign wr_index   = cur_index;
    assign wr_tag     = cur_tag;
    assign we         = (in_compare && !cache_hit) ? victim : '0;

    assign sel_index = cur_index;
    assign acc_valid = in_compare;
    assign acc_index = cur_index;
    assign acc_way   = cache_hit ? hit : victim;

    // ------------------------------
    // Response
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= in_compare;
        end
    end

    always_ff @(posedge clk) begin
        if (in_compare) begin
            resp_hit         <= cache_hit;
            resp_way         <= acc_way;
            resp_evict_tag   <= cache_hit ? '0 : replace_tag;
            resp_evict_valid <= cache_hit ? 1'b0 : replace_vld;
        end
    end

    // A miss fills exactly one way
    a_miss_fill_onehot : assert property (
        @(posedge clk) disable iff (reset)
        (in_compare && !cache_hit) |-> $onehot(we)
    ) else $error("lookup_ctrl: miss does not write exactly one way");

endmodule

//--- source/dcache_tag_top.sv
`timescale 1ns/1ps

module dcache_tag_top #(
    parameter int unsigned queue_depth = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req_valid,
    input  logic [cache_pkg::addr_w-1:0]   req_addr,
    output logic                           credit_return,
    output logic                           resp_valid,
    output logic                           resp_hit,
    output logic [cache_pkg::num_ways-1:0] resp_way,
    output logic [cache_pkg::tag_w-1:0]    resp_evict_tag,
    output logic                           resp_evict_valid
);
    import cache_pkg::*;

    // ------------------------------
    // Internal wires
    // ------------------------------
    logic                q_valid;
    logic [addr_w-1:0]   q_addr;
    logic                q_pop;
    logic [index_w-1:0]  rd_index;
    logic [index_w-1:0]  wr_index;
    logic [tag_w-1:0]    wr_tag;
    logic [tag_w-1:0]    lookup_tag;
    logic [num_ways-1:0] we;
    logic [num_ways-1:0] hit;
    logic                cache_hit;
    logic [tag_w-1:0]    replace_tag;
    logic                replace_vld;
    logic [index_w-1:0]  sel_index;
    logic [num_ways-1:0] victim;
    logic                acc_valid;
    logic [index_w-1:0]  acc_index;
    logic [num_ways-1:0] acc_way;

    lookup_queue #(
        .queue_depth (queue_depth)
    ) i_lookup_queue (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .q_valid       (q_valid),
        .q_addr        (q_addr),
        .q_pop         (q_pop),
        .credit_return (credit_return)
    );

    lookup_ctrl i_lookup_ctrl (
        .clk              (clk),
        .reset            (reset),
        .q_valid          (q_valid),
        .q_addr           (q_addr),
        .q_pop            (q_pop),
        .rd_index         (rd_index),
        .wr_index         (wr_index),
        .wr_tag           (wr_tag),
        .lookup_tag       (lookup_tag),
        .we               (we),
        .hit              (hit),
        .cache_hit        (cache_hit),
        .replace_tag      (replace_tag),
        .replace_vld      (replace_vld),
        .sel_index        (sel_index),
        .victim           (victim),
        .acc_valid        (acc_valid),
        .acc_index        (acc_index),
        .acc_way          (acc_way),
        .resp_valid       (resp_valid),
        .resp_hit         (resp_hit),
        .resp_way         (resp_way),
        .resp_evict_tag   (resp_evict_tag),
        .resp_evict_valid (resp_evict_valid)
    );

    // Victim doubles as the replace mux select
    tagv_memory i_tagv_memory (
        .clk         (clk),
        .reset       (reset),
        .rd_index    (rd_index),
        .wr_index    (wr_index),
        .wr_tag      (wr_tag),
        .lookup_tag  (lookup_tag),
        .we          (we),
        .way_sel     (victim),
        .hit         (hit),
        .cache_hit   (cache_hit),
        .replace_tag (replace_tag),
        .replace_vld (replace_vld)
    );

    plru_replacer i_plru_replacer (
        .clk       (clk),
        .reset     (reset),
        .sel_index (sel_index),
        .victim    (victim),
        .acc_valid (acc_valid),
        .acc_index (acc_index),
        .acc_way   (acc_way)
    );

endmodule

//--- tests/tb_cache_model.svh
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

// ------------------------------
// Reference tag model
// ------------------------------
logic [tag_w-1:0]  model_tag  [num_sets][num_ways];
logic              model_vld  [num_sets][num_ways];
logic [plru_w-1:0] model_tree [num_sets];

task automatic clear_model();
    for (int s = 0; s < num_sets; s++) begin
        model_tree[s] = '0;
        for (int w = 0; w < num_ways; w++) begin
            model_vld[s][w] = 1'b0;
        end
    end
endtask

// Lookup, fill on a miss and tree update, in request order
task automatic predict_access(
    input  logic [addr_w-1:0]   addr,
    output logic                hit,
    output logic [num_ways-1:0] way,
    output logic [tag_w-1:0]    evict_tag,
    output logic                evict_vld
);
    logic [tag_w-1:0]   tag;
    logic [index_w-1:0] idx;
    logic [plru_w-1:0]  tree;
    logic [1:0]         pick;
    tag       = addr[31:12];
    idx       = addr[11:6];
    tree      = model_tree[idx];
    hit       = 1'b0;
    pick      = 2'd0;
    evict_tag = '0;
    evict_vld = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
        if (model_vld[idx][w] && (model_tag[idx][w] == tag)) begin
            hit  = 1'b1;
            pick = 2'(w);
        end
    end
    if (!hit) begin
        // Root picks the pair, pair bit picks the way
        if (!tree[0]) begin
            pick = tree[1] ? 2'd1 : 2'd0;
        end else begin
            pick = tree[2] ? 2'd3 : 2'd2;
        end
        evict_tag = model_tag[idx][pick];
        evict_vld = model_vld[idx][pick];
        model_tag[idx][pick] = tag;
        model_vld[idx][pick] = 1'b1;
    end
    case (pick)
        2'd0: begin
            tree[0] = 1'b1;
            tree[1] = 1'b1;
        end
        2'd1: begin
            tree[0] = 1'b1;
            tree[1] = 1'b0;
        end
        2'd2: begin
            tree[0] = 1'b0;
            tree[2] = 1'b1;
        end
        default: begin
            tree[0] = 1'b0;
            tree[2] = 1'b0;
        end
    endcase
    model_tree[idx] = tree;
    way       = '0;
    way[pick] = 1'b1;
endtask

// 16-bit Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 16'hB400;
    end
    return next;
endfunction

`endif

//--- tests/tb_dcache_tag.sv
`timescale 1ns/1ps

module tb_dcache_tag;
    import cache_pkg::*;

    localparam int unsigned queue_depth = 4;
    localparam int          wait_limit  = 200;
    localparam int          row_count   = 22;

    localparam logic [1:0] mode_burst   = 2'd0;
    localparam logic [1:0] mode_drained = 2'd1;
    localparam logic [1:0] mode_reset   = 2'd2;

    logic                clk;
    logic                reset;
    logic                req_valid;
    logic [addr_w-1:0]   req_addr;
    logic                credit_return;
    logic                resp_valid;
    logic                resp_hit;
    logic [num_ways-1:0] resp_way;
    logic [tag_w-1:0]    resp_evict_tag;
    logic                resp_evict_valid;

    int          credits;
    logic [15:0] lfsr_state;
    // hit, way, evict tag, evict valid
    logic [25:0] expected_q [$];

    `include "tb_cache_model.svh"

    // ------------------------------
    // Stimulus table
    // ------------------------------
    // mode, expected hit, address
    localparam logic [34:0] stim_table [row_count] = '{
        // Cold misses on set 5
        {mode_drained, 1'b0, 32'h0000_1140},
        {mode_drained, 1'b0, 32'h0000_2140},
        {mode_drained, 1'b0, 32'h0000_3148},
        {mode_drained, 1'b0, 32'h0000_4140},
        {mode_drained, 1'b1, 32'h0000_1140},
        {mode_drained, 1'b1, 32'h0000_217C},
        {mode_drained, 1'b1, 32'h0000_3140},
        {mode_drained, 1'b1, 32'h0000_4140},
        // Fifth tag evicts, evicted tag then misses
        {mode_drained, 1'b0, 32'h0000_5140},
        {mode_drained, 1'b0, 32'h0000_1140},
        // Same tag in sets 9 and 10
        {mode_drained, 1'b0, 32'h0000_7240},
        {mode_drained, 1'b0, 32'h0000_7280},
        {mode_drained, 1'b1, 32'h0000_7240},
        {mode_drained, 1'b1, 32'h0000_7280},
        // Back to back, longer than the queue
        {mode_burst,   1'b1, 32'h0000_4140},
        {mode_burst,   1'b1, 32'h0000_3140},
        {mode_burst,   1'b0, 32'h0000_8500},
        {mode_burst,   1'b1, 32'h0000_8500},
        {mode_burst,   1'b0, 32'h0000_9500},
        {mode_burst,   1'b1, 32'h0000_7240},
        {mode_reset,   1'b0, 32'h0000_7240},
        {mode_drained, 1'b1, 32'h0000_7240}
    };

    dcache_tag_top #(
        .queue_depth (queue_depth)
    ) i_dcache_tag_top (
        .clk              (clk),
        .reset            (reset),
        .req_valid        (req_valid),
        .req_addr         (req_addr),
        .credit_return    (credit_return),
        .resp_valid       (resp_valid),
        .resp_hit         (resp_hit),
        .resp_way         (resp_way),
        .resp_evict_tag   (resp_evict_tag),
        .resp_evict_valid (resp_evict_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s at %0t", reason, $time);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int b = 0; b < count; b++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // ------------------------------
    // Cycle step and response check
    // ------------------------------
    task automatic step_cycle();
        logic [25:0] expected;
        @(negedge clk);
        req_valid = 1'b0;
        if (!reset) begin
            if (credit_return) begin
                if (credits >= int'(queue_depth)) begin
                    abort_run("Credit returned with no request outstanding");
                end else begin
                    credits = credits + 1;
                end
            end
            if (resp_valid) begin
                if (expected_q.size() == 0) begin
                    abort_run("Response arrived with no request outstanding");
                end else begin
                    expected = expected_q.pop_front();
                    compare_value("resp_hit", 32'(resp_hit), 32'(expected[25]));
                    compare_value("resp_way", 32'(resp_way), 32'(expected[24:21]));
                    compare_value("resp_evict_valid", 32'(resp_evict_valid),
                                  32'(expected[0]));
                    // Tag of an invalid victim is left unchecked
                    if (expected[25] || expected[0]) begin
                        compare_value("resp_evict_tag", 32'(resp_evict_tag),
                                      32'(expected[20:1]));
                    end
                end
            end
        end
    endtask

    task automatic await_credit();
        int cycles;
        cycles = 0;
        while (credits == 0) begin
            if (cycles >= wait_limit) begin
                abort_run("Timed out waiting for a returned credit");
            end else begin
                step_cycle();
                cycles++;
            end
        end
    endtask

    task automatic drain_outstanding();
        int cycles;
        cycles = 0;
        while ((credits != int'(queue_depth)) || (expected_q.size() != 0)) begin
            if (cycles >= wait_limit) begin
                abort_run("Timed out waiting for outstanding requests to finish");
            end else begin
                step_cycle();
                cycles++;
            end
        end
    endtask

    task automatic send_request(input logic [addr_w-1:0] addr, input logic exp_hit);
        logic                model_hit;
        logic [num_ways-1:0] way;
        logic [tag_w-1:0]    evict_tag;
        logic                evict_vld;
        step_cycle();
        await_credit();
        predict_access(addr, model_hit, way, evict_tag, evict_vld);
        compare_value("model hit", 32'(model_hit), 32'(exp_hit));
        expected_q.push_back({exp_hit, way, evict_tag, evict_vld});
        req_valid = 1'b1;
        req_addr  = addr;
        credits   = credits - 1;
    endtask

    task automatic pulse_reset();
        step_cycle();
        reset = 1'b1;
        repeat (5) step_cycle();
        reset = 1'b0;
        clear_model();
        credits = queue_depth;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [34:0] row;
        logic [1:0]  mode;
        int          gap;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        credits    = queue_depth;
        lfsr_state = 16'd22994;
        clear_model();
        repeat (5) step_cycle();
        reset = 1'b0;

        for (int i = 0; i < row_count; i++) begin
            row  = stim_table[i];
            mode = row[34:33];
            if (mode == mode_reset) begin
                drain_outstanding();
                pulse_reset();
            end else if (mode == mode_drained) begin
                drain_outstanding();
                gap = random_bits(2);
                repeat (gap) step_cycle();
            end
            send_request(row[31:0], row[32]);
        end

        drain_outstanding();
        // Quiet tail catches stray responses or credits
        repeat (8) step_cycle();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+tests
source/cache_pkg.sv
source/tagv_ram.sv
source/tagv_memory.sv
source/plru_replacer.sv
source/lookup_queue.sv
source/lookup_ctrl.sv
source/dcache_tag_top.sv
tests/tb_dcache_tag.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the tag-side testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module tb_dcache_tag \
    -Mdir "$build_dir" \
    -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

"./$build_dir/Vtb_dcache_tag"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
